// File: source/dma_buf_pkg.sv
// data-path types only; a buffer row is one byte and is read back as two nibbles, low first
package dma_buf_pkg;

    // cpu side data unit
    typedef logic [7:0] byte_t;             // one byte from the cpu

    // memory side data unit
    typedef logic [3:0] nibble_t;           // one nibble toward memory

    // one buffer row, written as a byte and read as two nibbles
    // n[0] overlays bits 3:0, n[1] overlays bits 7:4
    typedef union packed
    {
        byte_t        b;                    // write view
        nibble_t [1:0] n;                   // read view, index 0 is low nibble
    } buf_word_u;

    // both views share the same 8 bits
    // a byte written through b is drained as n[0] then n[1]
    // nothing else is kept per row

endpackage

// File: source/dma_desc_pkg.sv
// descriptor field types; lengths count bytes and are limited to 16 bits
package dma_desc_pkg;

    // target memory address, passed through unchanged
    typedef logic [31:0] addr_t;            // byte address

    // transfer length in bytes, zero allowed
    typedef logic [15:0] len_t;             // up to 65535 bytes

    // a zero length moves the address only

endpackage

// File: source/desc_ctrl.sv
// one descriptor in flight at a time; a new one is taken only after all 2*len nibbles have left
`timescale 1ns/1ns

module desc_ctrl (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 desc_valid,
    input  dma_desc_pkg::addr_t  desc_addr,
    input  dma_desc_pkg::len_t   desc_len,
    input  logic                 mem_addr_ready,
    input  logic                 byte_taken,
    input  logic                 nibble_taken,
    output logic                 desc_ready,
    output logic                 mem_addr_valid,
    output dma_desc_pkg::addr_t  mem_addr,
    output logic                 cpu_open,
    output logic                 mem_open,
    output logic                 last_byte
);

    localparam logic [1:0] ST_IDLE = 2'd0;  // waiting for a descriptor
    localparam logic [1:0] ST_ADDR = 2'd1;  // address offered to memory
    localparam logic [1:0] ST_MOVE = 2'd2;  // data moving

    logic [1:0]           state;
    dma_desc_pkg::addr_t  addr_q;           // latched start address
    dma_desc_pkg::len_t   len_q;            // latched byte count
    dma_desc_pkg::len_t   byte_cnt;         // bytes taken from cpu
    logic [16:0]          nib_cnt;          // nibbles sent to memory
    logic                 nib_done;         // final nibble of descriptor

    assign desc_ready     = (state == ST_IDLE);
    assign mem_addr_valid = (state == ST_ADDR);
    assign mem_addr       = addr_q;

    // high on the transfer of byte len-1
    assign last_byte = byte_taken && (byte_cnt == len_q - 16'd1);

    // 2*len nibbles per descriptor
    assign nib_done = nibble_taken && (nib_cnt == {len_q, 1'b0} - 17'd1);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state    <= ST_IDLE;
            cpu_open <= 1'b0;
            mem_open <= 1'b0;
            byte_cnt <= '0;
            nib_cnt  <= '0;
            addr_q   <= '0;
            len_q    <= '0;
        end
        else
        begin
            // bytes count in every state once cpu_open is up
            if (byte_taken)
                byte_cnt <= byte_cnt + 16'd1;
            if (last_byte)
                cpu_open <= 1'b0;               // no more cpu bytes
            case (state)
                ST_IDLE:
                begin
                    if (desc_valid)
                    begin
                        addr_q   <= desc_addr;
                        len_q    <= desc_len;
                        cpu_open <= (desc_len != '0);  // cpu side opens early
                        state    <= ST_ADDR;
                    end
                end
                ST_ADDR:
                begin
                    if (mem_addr_ready)
                    begin
                        mem_open <= (len_q != '0);
                        // zero length goes straight back to idle
                        state    <= (len_q == '0) ? ST_IDLE : ST_MOVE;
                    end
                end
                default:
                begin
                    if (nibble_taken)
                        nib_cnt <= nib_cnt + 17'd1;
                    if (nib_done)
                    begin
                        // everything has left, rearm for the next descriptor
                        nib_cnt  <= '0;
                        byte_cnt <= '0;
                        mem_open <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // the feeder may only take a byte while the count is below the length
    a_byte_bound: assert property (@(posedge clk) disable iff (!resetn)
        byte_taken |-> (byte_cnt < len_q));

endmodule

// File: source/byte_intake.sv
// buffer writable flags must mean empty; the select only moves off a sealed buffer
`timescale 1ns/1ns

module byte_intake (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 cpu_valid,
    input  dma_buf_pkg::byte_t   cpu_data,
    input  logic                 cpu_open,
    input  logic                 last_byte,
    input  logic [1:0]           buf_writable,
    input  logic [1:0]           buf_sealed,
    output logic                 cpu_ready,
    output logic                 byte_taken,
    output logic [1:0]           buf_wr,
    output logic [1:0]           buf_seal,
    output dma_buf_pkg::byte_t   buf_wr_data
);

    logic fill_sel;                         // buffer being filled
    logic other_sel;                        // the partner buffer

    assign other_sel = ~fill_sel;

    // ready only into a buffer that still takes rows
    assign cpu_ready  = cpu_open && buf_writable[fill_sel];
    assign byte_taken = cpu_valid && cpu_ready;

    // steer the write and seal to the filling buffer
    always_comb
    begin
        buf_wr   = 2'b00;
        buf_seal = 2'b00;
        buf_wr[fill_sel]   = byte_taken;
        buf_seal[fill_sel] = last_byte;     // early seal on final byte
    end

    assign buf_wr_data = cpu_data;          // same byte to both, wr picks

    // move on once ours is sealed and the partner is empty again
    always_ff @(posedge clk)
    begin
        if (!resetn)
            fill_sel <= 1'b0;
        else if (buf_sealed[fill_sel] && buf_writable[other_sel])
            fill_sel <= other_sel;
    end

endmodule

// File: source/pingpong_buffer.sv
// DEPTH of 2 or more; rd is only honoured while sealed, wr only while writable
`timescale 1ns/1ns

module pingpong_buffer #(
    parameter int DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  wr,
    input  logic                  seal,
    input  dma_buf_pkg::byte_t    wr_data,
    input  logic                  rd,
    output logic                  writable,
    output logic                  sealed,
    output logic                  last,
    output dma_buf_pkg::nibble_t  rd_nibble
);

    localparam int AW = $clog2(DEPTH);      // row index width

    dma_buf_pkg::buf_word_u mem [DEPTH];    // row storage
    logic [AW:0]            wr_cnt;         // rows written, 0..DEPTH
    logic [AW-1:0]          rd_row;         // row being drained
    logic                   half;           // 0 low nibble, 1 high nibble
    logic                   sealed_q;

    assign sealed   = sealed_q;
    assign writable = !sealed_q;            // unsealed means empty or filling

    // nibble view of the current row
    assign rd_nibble = mem[rd_row].n[half];

    // high nibble of the last written row
    assign last = sealed_q && half && (({1'b0, rd_row} + 1'b1) == wr_cnt);

    // byte view on write
    always_ff @(posedge clk)
    begin
        if (wr)
            mem[wr_cnt[AW-1:0]].b <= wr_data;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            wr_cnt   <= '0;
            rd_row   <= '0;
            half     <= 1'b0;
            sealed_q <= 1'b0;
        end
        else if (sealed_q)
        begin
            if (rd)
            begin
                if (last)
                begin
                    // drained, back to empty
                    wr_cnt   <= '0;
                    rd_row   <= '0;
                    half     <= 1'b0;
                    sealed_q <= 1'b0;
                end
                else if (half)
                begin
                    half   <= 1'b0;
                    rd_row <= rd_row + 1'b1;    // next row
                end
                else
                    half <= 1'b1;               // low done, high next
            end
        end
        else if (wr)
        begin
            wr_cnt <= wr_cnt + 1'b1;
            // full or final descriptor byte
            if (seal || (wr_cnt == (AW + 1)'(DEPTH - 1)))
                sealed_q <= 1'b1;
        end
    end

    // the feeder must have moved away before writing again
    a_no_wr_sealed: assert property (@(posedge clk) disable iff (!resetn)
        wr |-> !sealed_q);

endmodule

// File: source/nibble_drain.sv
// drains buffers strictly in the order they were filled, starting with buffer 0
`timescale 1ns/1ns

module nibble_drain (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        mem_open,
    input  logic                        mem_ready,
    input  logic [1:0]                  buf_sealed,
    input  logic [1:0]                  buf_last,
    input  dma_buf_pkg::nibble_t [1:0]  buf_nibble,
    output logic                        mem_valid,
    output dma_buf_pkg::nibble_t        mem_data,
    output logic                        nibble_taken,
    output logic [1:0]                  buf_rd
);

    logic drain_sel;                        // buffer being drained

    // valid only from a sealed buffer
    assign mem_valid    = mem_open && buf_sealed[drain_sel];
    assign mem_data     = buf_nibble[drain_sel];
    assign nibble_taken = mem_valid && mem_ready;

    // read strobe back to the draining buffer
    always_comb
    begin
        buf_rd = 2'b00;
        buf_rd[drain_sel] = nibble_taken;
    end

    // switch on the edge that takes the final nibble
    always_ff @(posedge clk)
    begin
        if (!resetn)
            drain_sel <= 1'b0;
        else if (nibble_taken && buf_last[drain_sel])
            drain_sel <= ~drain_sel;
    end

    // held offer stays put until memory takes it
    a_hold_data: assert property (@(posedge clk) disable iff (!resetn)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_data)));

endmodule

// File: source/dma_cpu_to_mem.sv
// cpu-to-memory direction only; each cpu byte leaves as two nibbles, low nibble first
`timescale 1ns/1ns

module dma_cpu_to_mem #(
    parameter int DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  desc_valid,
    input  dma_desc_pkg::addr_t   desc_addr,
    input  dma_desc_pkg::len_t    desc_len,
    output logic                  desc_ready,
    output logic                  mem_addr_valid,
    output dma_desc_pkg::addr_t   mem_addr,
    input  logic                  mem_addr_ready,
    input  logic                  cpu_valid,
    input  dma_buf_pkg::byte_t    cpu_data,
    output logic                  cpu_ready,
    output logic                  mem_valid,
    output dma_buf_pkg::nibble_t  mem_data,
    input  logic                  mem_ready
);

    logic                        cpu_open;      // cpu side may send
    logic                        mem_open;      // memory side may receive
    logic                        last_byte;     // final byte of descriptor
    logic                        byte_taken;
    logic                        nibble_taken;
    logic [1:0]                  buf_wr;
    logic [1:0]                  buf_seal;
    logic [1:0]                  buf_rd;
    logic [1:0]                  buf_writable;
    logic [1:0]                  buf_sealed;
    logic [1:0]                  buf_last;
    dma_buf_pkg::byte_t          buf_wr_data;
    dma_buf_pkg::nibble_t [1:0]  buf_nibble;

    desc_ctrl desc_ctrl_inst (
        .clk            (clk),
        .resetn         (resetn),
        .desc_valid     (desc_valid),
        .desc_addr      (desc_addr),
        .desc_len       (desc_len),
        .mem_addr_ready (mem_addr_ready),
        .byte_taken     (byte_taken),
        .nibble_taken   (nibble_taken),
        .desc_ready     (desc_ready),
        .mem_addr_valid (mem_addr_valid),
        .mem_addr       (mem_addr),
        .cpu_open       (cpu_open),
        .mem_open       (mem_open),
        .last_byte      (last_byte)
    );

    byte_intake byte_intake_inst (
        .clk          (clk),
        .resetn       (resetn),
        .cpu_valid    (cpu_valid),
        .cpu_data     (cpu_data),
        .cpu_open     (cpu_open),
        .last_byte    (last_byte),
        .buf_writable (buf_writable),
        .buf_sealed   (buf_sealed),
        .cpu_ready    (cpu_ready),
        .byte_taken   (byte_taken),
        .buf_wr       (buf_wr),
        .buf_seal     (buf_seal),
        .buf_wr_data  (buf_wr_data)
    );

    // ping and pong
    for (genvar i = 0; i < 2; i++)
    begin : g_buf
        pingpong_buffer #(
            .DEPTH (DEPTH)
        ) pingpong_buffer_inst (
            .clk       (clk),
            .resetn    (resetn),
            .wr        (buf_wr[i]),
            .seal      (buf_seal[i]),
            .wr_data   (buf_wr_data),
            .rd        (buf_rd[i]),
            .writable  (buf_writable[i]),
            .sealed    (buf_sealed[i]),
            .last      (buf_last[i]),
            .rd_nibble (buf_nibble[i])
        );
    end

    nibble_drain nibble_drain_inst (
        .clk          (clk),
        .resetn       (resetn),
        .mem_open     (mem_open),
        .mem_ready    (mem_ready),
        .buf_sealed   (buf_sealed),
        .buf_last     (buf_last),
        .buf_nibble   (buf_nibble),
        .mem_valid    (mem_valid),
        .mem_data     (mem_data),
        .nibble_taken (nibble_taken),
        .buf_rd       (buf_rd)
    );

endmodule

// File: sim/tb_dma_cpu_to_mem.sv
// DEPTH fixed at 8 here; cpu bytes are offered from the cycle after the descriptor is taken
`timescale 1ns/1ns

module tb_dma_cpu_to_mem;

    typedef dma_buf_pkg::byte_t byte_list_t [$];

    localparam int NRAND = 6;                       // random descriptors in test 5

    logic                  clk;
    logic                  resetn;
    logic                  desc_valid;
    dma_desc_pkg::addr_t   desc_addr;
    dma_desc_pkg::len_t    desc_len;
    logic                  desc_ready;
    logic                  mem_addr_valid;
    dma_desc_pkg::addr_t   mem_addr;
    logic                  mem_addr_ready;
    logic                  cpu_valid;
    dma_buf_pkg::byte_t    cpu_data;
    logic                  cpu_ready;
    logic                  mem_valid;
    dma_buf_pkg::nibble_t  mem_data;
    logic                  mem_ready;

    integer                seed;                    // $random state
    byte_list_t            exp_bytes;               // bytes of the current descriptor
    dma_desc_pkg::addr_t   exp_addr;
    int                    exp_len;
    int                    nib_idx;                 // nibbles seen so far
    int                    addr_count;              // address transfers seen
    bit                    busy;                    // descriptor in flight
    bit                    cpu_ready_seen;
    bit                    mem_gaps;                // memory side stalls on
    bit                    gap_table [256];         // precomputed mem_ready pattern
    int                    cyc;
    int                    err_count;
    int                    test_num;
    int                    test_ok;
    int                    test_bad;
    int                    test_err_start;
    longint                limit_ns;
    int                    rand_len [NRAND];

    dma_cpu_to_mem #(
        .DEPTH (8)
    ) dma_cpu_to_mem_inst (
        .clk            (clk),
        .resetn         (resetn),
        .desc_valid     (desc_valid),
        .desc_addr      (desc_addr),
        .desc_len       (desc_len),
        .desc_ready     (desc_ready),
        .mem_addr_valid (mem_addr_valid),
        .mem_addr       (mem_addr),
        .mem_addr_ready (mem_addr_ready),
        .cpu_valid      (cpu_valid),
        .cpu_data       (cpu_data),
        .cpu_ready      (cpu_ready),
        .mem_valid      (mem_valid),
        .mem_data       (mem_data),
        .mem_ready      (mem_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    // byte k leaves as nibble 2k (low half) then 2k+1 (high half)
    function automatic dma_buf_pkg::nibble_t expected_nibble(input byte_list_t bytes,
                                                             input int idx);
        dma_buf_pkg::byte_t b;
        b = bytes[idx / 2];
        if ((idx % 2) == 0)
            return b[3:0];
        return b[7:4];
    endfunction

    task automatic check_nibble(input dma_buf_pkg::nibble_t got,
                                input dma_buf_pkg::nibble_t exp, input int idx);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: nibble %0d is %h, expected %h", $time, idx, got, exp);
            err_count++;
        end
    endtask

    task automatic check_addr(input dma_desc_pkg::addr_t got, input dma_desc_pkg::addr_t exp);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: mem_addr is %h, expected %h", $time, got, exp);
            err_count++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic begin_test();
        test_num++;
        test_err_start = err_count;
    endtask

    task automatic end_test(input string name);
        if (err_count == test_err_start)
        begin
            $display("test %0d %s: ok", test_num, name);
            test_ok++;
        end
        else
        begin
            $display("test %0d %s: FAILED with %0d errors", test_num, name,
                     err_count - test_err_start);
            test_bad++;
        end
    endtask

    // one descriptor end to end; entered and left 1 ns after a rising edge
    task automatic run_descriptor(input dma_desc_pkg::addr_t addr, input dma_desc_pkg::len_t len,
                                  input int addr_delay, input bit gaps);
        int k;
        bit taken;
        exp_bytes.delete();
        for (k = 0; k < int'(len); k++)
            exp_bytes.push_back(dma_buf_pkg::byte_t'($random(seed)));
        exp_addr       = addr;
        exp_len        = int'(len);
        nib_idx        = 0;
        addr_count     = 0;
        cpu_ready_seen = 1'b0;
        desc_valid     = 1'b1;
        desc_addr      = addr;
        desc_len       = len;
        @(posedge clk);
        while (!desc_ready)
            @(posedge clk);
        #1;
        desc_valid = 1'b0;
        busy       = 1'b1;                          // desc_ready must stay low now
        check_flag(mem_addr_valid, 1'b1, "mem_addr_valid after descriptor");
        fork
            begin
                // memory may be slow to take the address
                repeat (addr_delay)
                    @(posedge clk);
                if (addr_delay > 0)
                    #1;
                mem_addr_ready = 1'b1;
                @(posedge clk);
                while (!mem_addr_valid)
                    @(posedge clk);
                #1;
                mem_addr_ready = 1'b0;
                check_flag(mem_addr_valid, 1'b0, "mem_addr_valid after address transfer");
            end
            begin
                // cpu bytes overlap the address hand-off
                k = 0;
                while (k < exp_len)
                begin
                    if (!cpu_valid && (!gaps || (($random(seed) & 3) != 0)))
                    begin
                        cpu_valid = 1'b1;           // held until taken
                        cpu_data  = exp_bytes[k];
                    end
                    @(posedge clk);
                    taken = cpu_valid && cpu_ready;
                    #1;
                    if (taken)
                    begin
                        k++;
                        cpu_valid = 1'b0;
                    end
                end
            end
        join
        @(posedge clk);
        while (!desc_ready)
            @(posedge clk);
        #1;
        busy = 1'b0;
        check_count(nib_idx, 2 * exp_len, "nibbles delivered");
    endtask

    // memory side ready, stalls from the table when enabled
    initial
    begin
        forever
        begin
            @(posedge clk);
            #1;
            mem_ready = mem_gaps ? gap_table[cyc % 256] : 1'b1;
            cyc++;
        end
    end

    // compares every transfer toward memory
    initial
    begin
        forever
        begin
            @(posedge clk);
            if (resetn)
            begin
                if (mem_addr_valid && mem_addr_ready)
                begin
                    check_addr(mem_addr, exp_addr);
                    addr_count++;
                end
                if (mem_valid && mem_ready)
                begin
                    if (nib_idx >= 2 * exp_len)
                    begin
                        $display("error at %0t ns: a nibble arrived past the descriptor length",
                                 $time);
                        err_count++;
                    end
                    else
                        check_nibble(mem_data, expected_nibble(exp_bytes, nib_idx), nib_idx);
                    nib_idx++;
                end
                if (cpu_ready)
                    cpu_ready_seen = 1'b1;
                if (busy && desc_ready && !(addr_count > 0 && nib_idx >= 2 * exp_len))
                begin
                    $display("error at %0t ns: desc_ready rose before the descriptor finished",
                             $time);
                    err_count++;
                end
            end
        end
    end

    initial
    begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("timeout: the run did not complete within %0d ns", limit_ns);
        $display("tests failed");
        $finish;
    end

    initial
    begin
        int total;
        seed           = 32'h934e_edd4;
        resetn         = 1'b0;
        desc_valid     = 1'b0;
        desc_addr      = '0;
        desc_len       = '0;
        mem_addr_ready = 1'b0;
        cpu_valid      = 1'b0;
        cpu_data       = '0;
        mem_ready      = 1'b0;
        mem_gaps       = 1'b0;
        busy           = 1'b0;
        cyc            = 0;
        err_count      = 0;
        test_num       = 0;
        test_ok        = 0;
        test_bad       = 0;
        exp_len        = 0;
        for (int i = 0; i < 256; i++)
            gap_table[i] = (($random(seed) & 3) != 0);    // ready three cycles in four
        total = 3 + 24 + 5;
        for (int i = 0; i < NRAND; i++)
        begin
            rand_len[i] = 1 + int'($unsigned($random(seed)) % 20);
            total += rand_len[i];
        end
        limit_ns = longint'(total) * 40 * 4 + 2000;
        repeat (5)
            @(posedge clk);
        #1;
        resetn = 1'b1;

        begin_test();
        check_flag(desc_ready, 1'b1, "desc_ready after reset");
        check_flag(cpu_ready, 1'b0, "cpu_ready after reset");
        check_flag(mem_addr_valid, 1'b0, "mem_addr_valid after reset");
        check_flag(mem_valid, 1'b0, "mem_valid after reset");
        end_test("reset values");

        begin_test();
        run_descriptor(32'h8000_1234, 16'd3, 3, 1'b0);    // memory slow to take address
        end_test("address hand-off");

        begin_test();
        run_descriptor(32'h0000_4000, 16'd24, 0, 1'b0);
        end_test("length 24, three full buffers");

        begin_test();
        run_descriptor(32'h0000_5550, 16'd5, 1, 1'b0);
        end_test("length 5, early seal");

        begin_test();
        mem_gaps = 1'b1;
        for (int i = 0; i < NRAND; i++)
            run_descriptor($random(seed), dma_desc_pkg::len_t'(rand_len[i]),
                           $random(seed) & 3, 1'b1);
        mem_gaps = 1'b0;
        end_test("random lengths with stalls");

        begin_test();
        run_descriptor(32'h0000_6660, 16'd0, 2, 1'b0);
        check_flag(cpu_ready_seen, 1'b0, "cpu_ready seen for zero length");
        end_test("length 0");

        $display("summary: %0d run, %0d ok, %0d not ok, %0d errors",
                 test_num, test_ok, test_bad, err_count);
        if (err_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: compile.f
source/dma_buf_pkg.sv
source/dma_desc_pkg.sv
source/desc_ctrl.sv
source/byte_intake.sv
source/pingpong_buffer.sv
source/nibble_drain.sv
source/dma_cpu_to_mem.sv
sim/tb_dma_cpu_to_mem.sv

// File: Makefile
SIM  = obj_dir/Vtb_dma_cpu_to_mem
SRCS = $(wildcard source/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_dma_cpu_to_mem -Mdir obj_dir

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
